/* verilog.f */
+incdir+include
design/cart_pkg.sv
design/cart_header_parser.sv
design/save_dirty_tracker.sv
design/backup_sync_sequencer.sv
design/cart_manager_top.sv
tests/tb_cart_manager.sv

/* Makefile */
# Verilator simulation of the cartridge manager

.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/100ps -f verilog.f \
		--top-module tb_cart_manager -o tb_cart_manager
	./obj_dir/tb_cart_manager | tee /dev/stderr | grep -q "^TEST PASS$$"

clean:
	rm -rf obj_dir

/* tests/tb_cart_manager.sv */
/*
 * Cartridge manager testbench
 * Random header downloads, region selection, save enable and
 * backup RAM load and autosave against a behavioral model
 */
`timescale 1ns/100ps
`include "cart_config.svh"

module tb_cart_manager import cart_pkg::*; ();

	// Up to four syncs of 32 sectors at about 20 cycles each
	// plus some 60 short downloads and a wide margin
	localparam int TIMEOUT_CYCLES = 20000;

	logic        clk_sys;
	logic        reset;
	logic        ioctl_download;
	logic [7:0]  ioctl_index;
	logic        ioctl_wr;
	logic [24:0] ioctl_addr;
	logic [15:0] ioctl_dout;
	rom_layout_e rom_layout;
	region_sel_e video_region;
	logic        osd_status;
	logic        autosave;
	logic        bk_load;
	logic        bk_save;
	logic        img_mounted;
	logic        img_readonly;
	logic [63:0] img_size;
	logic        bsram_ce_n;
	logic        bsram_we_n;
	logic        sd_ack;
	logic [31:0] sd_lba;
	logic        sd_rd;
	logic        sd_wr;
	logic        cart_download;
	logic [7:0]  rom_type;
	logic [23:0] rom_mask;
	logic [23:0] ram_mask;
	logic        pal;
	logic        bk_ena;
	logic        bk_busy;
	logic        bk_loading;
	logic        led_user;

	int          errors = 0;
	int          cycle_count;
	int          rd_count = 0;
	int          wr_count = 0;
	logic [31:0] last_lba = 32'd0;
	integer      seed = 32'h286e;
	integer      ack_seed = 32'h286e;

	cart_manager_top uut (.*);

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	// ============================================================
	// Model and check helpers
	// ============================================================

	// A size code n covers 1024 << n bytes and the mask saturates at the 24-bit space
	function automatic logic [23:0] size_mask(input logic [3:0] size);
		logic [39:0] bytes;
		bytes = {16'd0, `CART_MASK_BASE} << size;
		return (bytes > 40'h1000000) ? 24'hFFFFFF : 24'(bytes - 40'd1);
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			errors++;
			$display("FAIL %s: expected %0h, actual %0h", name, expected, actual);
		end
	endtask

	task automatic check_header(input string name, input logic [7:0] exp_type,
			input logic [3:0] rom_sz, input logic [3:0] ram_sz);
		logic [23:0] exp_ram;
		exp_ram = (ram_sz == 4'd0) ? 24'd0 : size_mask(ram_sz);
		check_value({name, " rom_type"}, 32'(exp_type), 32'(rom_type));
		check_value({name, " rom_mask"}, 32'(size_mask(rom_sz)), 32'(rom_mask));
		check_value({name, " ram_mask"}, 32'(exp_ram), 32'(ram_mask));
	endtask

	// ============================================================
	// Bus tasks
	// ============================================================

	task automatic start_download();
		@(posedge clk_sys);
		ioctl_index    <= 8'd0;
		ioctl_download <= 1'b1;
		@(negedge clk_sys);
		check_value("cart_download", 32'd1, 32'(cart_download));
		check_value("led during download", 32'd1, 32'(led_user));
	endtask

	task automatic write_word(input logic [24:0] addr, input logic [15:0] data);
		@(posedge clk_sys);
		ioctl_addr <= addr;
		ioctl_dout <= data;
		ioctl_wr   <= 1'b1;
		@(posedge clk_sys);
		ioctl_wr   <= 1'b0;
	endtask

	// Outputs settle two cycles after the download ends
	task automatic finish_download(input int hold);
		repeat (hold) @(posedge clk_sys);
		ioctl_download <= 1'b0;
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
	endtask

	task automatic save_ram_write();
		@(posedge clk_sys);
		bsram_ce_n <= 1'b0;
		bsram_we_n <= 1'b0;
		@(posedge clk_sys);
		bsram_ce_n <= 1'b1;
		bsram_we_n <= 1'b1;
	endtask

	task automatic wait_sync_done(input string name);
		int waited;
		waited = 0;
		while (!bk_busy && waited < 100) begin
			@(negedge clk_sys);
			waited++;
		end
		if (!bk_busy) begin
			errors++;
			$display("%s: backup RAM sync never started", name);
		end else begin
			waited = 0;
			while (bk_busy && waited < 2000) begin
				@(negedge clk_sys);
				waited++;
			end
			if (bk_busy) begin
				errors++;
				$display("%s: backup RAM sync never finished", name);
			end
		end
	endtask

	// SD host with random ack latency that counts sectors per direction
	initial begin : sd_responder
		integer rnd_ack;
		sd_ack <= 1'b0;
		forever begin
			@(negedge clk_sys);
			if (sd_rd || sd_wr) begin
				if (sd_rd) begin
					check_value("sd_lba read order", rd_count, sd_lba);
					check_value("bk_loading on read", 32'd1, 32'(bk_loading));
					rd_count++;
				end else begin
					check_value("sd_lba write order", wr_count, sd_lba);
					check_value("bk_loading on write", 32'd0, 32'(bk_loading));
					wr_count++;
				end
				last_lba = sd_lba;
				rnd_ack = $random(ack_seed);
				@(posedge clk_sys);
				repeat (int'(rnd_ack[2:0])) @(posedge clk_sys);
				sd_ack <= 1'b1;
				rnd_ack = $random(ack_seed);
				repeat (int'(rnd_ack[2:0]) + 1) @(posedge clk_sys);
				sd_ack <= 1'b0;
			end
		end
	end

	initial begin : watchdog
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge clk_sys);
			cycle_count++;
		end
		$display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("TEST FAIL");
		$finish;
	end

	// ============================================================
	// Stimulus
	// ============================================================

	initial begin : stimulus
		integer      rnd;
		logic [15:0] word;
		logic [15:0] size_word;
		logic [15:0] ram_word;
		logic [3:0]  rom_sz;
		logic [3:0]  ram_sz;
		logic [7:0]  exp_type;
		logic [24:0] base;
		logic        exp_pal;
		logic [23:0] exp_ram_mask;
		int          sectors;
		rom_layout_e layouts [4];

		layouts = '{LAYOUT_NO_HEADER, LAYOUT_LOROM, LAYOUT_HIROM, LAYOUT_EXHIROM};
		reset          <= 1'b0;
		ioctl_download <= 1'b0;
		ioctl_index    <= 8'hFF;
		ioctl_wr       <= 1'b0;
		ioctl_addr     <= 25'd0;
		ioctl_dout     <= 16'd0;
		rom_layout     <= LAYOUT_AUTO;
		video_region   <= REGION_AUTO;
		osd_status     <= 1'b0;
		autosave       <= 1'b0;
		bk_load        <= 1'b0;
		bk_save        <= 1'b0;
		img_mounted    <= 1'b0;
		img_readonly   <= 1'b0;
		img_size       <= 64'd0;
		bsram_ce_n     <= 1'b1;
		bsram_we_n     <= 1'b1;
		repeat (8) @(posedge clk_sys);
		reset <= 1'b1;

		// Auto layout where every fifth word has a zero size byte
		for (int i = 0; i < 20; i++) begin
			rnd = $random(seed);
			word = rnd[15:0];
			if (i % 5 == 0)
				word[7:0] = 8'd0;
			start_download();
			write_word(25'd0, word);
			finish_download(1);
			rom_sz = (word[7:0] != 8'd0) ? word[3:0] : `CART_DEFAULT_ROM_SIZE;
			ram_sz = (word[7:0] != 8'd0) ? word[7:4] : 4'd0;
			check_header("auto", word[15:8], rom_sz, ram_sz);
		end

		// Non-cartridge index leaves the header alone
		@(posedge clk_sys);
		ioctl_index    <= 8'hFF;
		ioctl_download <= 1'b1;
		@(negedge clk_sys);
		check_value("other index cart_download", 32'd0, 32'(cart_download));
		check_value("other index led", 32'd0, 32'(led_user));
		rnd = $random(seed);
		write_word(25'd0, rnd[15:0]);
		finish_download(1);
		check_header("other index", word[15:8], rom_sz, ram_sz);

		// Forced layouts where no-header ignores the LoROM fields
		for (int l = 0; l < 4; l++) begin
			@(posedge clk_sys);
			rom_layout <= layouts[l];
			case (layouts[l])
				LAYOUT_HIROM:   base = `CART_HIROM_SIZE_ADDR;
				LAYOUT_EXHIROM: base = `CART_EXHIROM_SIZE_ADDR;
				default:        base = `CART_LOROM_SIZE_ADDR;
			endcase
			case (layouts[l])
				LAYOUT_HIROM:   exp_type = 8'd1;
				LAYOUT_EXHIROM: exp_type = 8'd2;
				default:        exp_type = 8'd0;
			endcase
			for (int i = 0; i < 4; i++) begin
				rnd = $random(seed);
				size_word = rnd[15:0];
				rnd = $random(seed);
				ram_word = rnd[15:0];
				rnd = $random(seed);
				word = rnd[15:0];
				start_download();
				write_word(25'd0, word);
				write_word(base + `CART_HEADER_SKIP, size_word);
				write_word(base + `CART_HEADER_SKIP + 25'd2, ram_word);
				finish_download(1);
				if (layouts[l] == LAYOUT_NO_HEADER) begin
					rom_sz = `CART_DEFAULT_ROM_SIZE;
					ram_sz = 4'd0;
				end else begin
					rom_sz = size_word[11:8];
					ram_sz = ram_word[3:0];
				end
				check_header("forced", exp_type, rom_sz, ram_sz);
			end
		end
		@(posedge clk_sys);
		rom_layout <= LAYOUT_AUTO;

		// Region selection
		for (int r = 0; r < 4; r++) begin
			@(posedge clk_sys);
			video_region <= region_sel_e'(r[1:0]);
			for (int i = 0; i < 4; i++) begin
				rnd = $random(seed);
				word = rnd[15:0];
				start_download();
				write_word(`CART_REGION_ADDR, word);
				finish_download(1);
				exp_pal = (r == 0) ? word[8] : (r != 1);
				check_value("region pal", 32'(exp_pal), 32'(pal));
			end
		end

		// Save enable and automatic load after the download
		@(posedge clk_sys);
		img_mounted <= 1'b1;
		img_size    <= 64'h2000;
		exp_ram_mask = 24'd0;
		for (int i = 0; i < 4; i++) begin
			rnd = $random(seed);
			rom_sz = rnd[3:0];
			ram_sz = {2'b00, rnd[5:4]} + {3'b000, rnd[6]};
			if (i == 0)
				ram_sz = 4'd0;
			if (i == 3 && ram_sz == 4'd0)
				ram_sz = 4'd3;
			exp_ram_mask = (ram_sz == 4'd0) ? 24'd0 : size_mask(ram_sz);
			rd_count = 0;
			start_download();
			write_word(25'd0, {8'h00, ram_sz, rom_sz});
			finish_download(3);
			check_value("bk_ena", 32'(exp_ram_mask != 24'd0), 32'(bk_ena));
			if (exp_ram_mask != 24'd0) begin
				wait_sync_done("auto load");
				sectors = int'(exp_ram_mask >> `CART_SECTOR_BITS) + 1;
				check_value("load sectors", sectors, rd_count);
				check_value("load last lba", sectors - 1, last_lba);
			end else begin
				repeat (10) @(negedge clk_sys);
				check_value("load sectors", 32'd0, rd_count);
			end
		end

		// Dirty tracking and autosave on menu open
		@(posedge clk_sys);
		autosave <= 1'b1;
		wr_count = 0;
		save_ram_write();
		repeat (2) @(negedge clk_sys);
		check_value("led after write", 32'd1, 32'(led_user));
		@(posedge clk_sys);
		osd_status <= 1'b1;
		wait_sync_done("autosave");
		sectors = int'(exp_ram_mask >> `CART_SECTOR_BITS) + 1;
		check_value("save sectors", sectors, wr_count);
		check_value("led after save", 32'd0, 32'(led_user));
		@(posedge clk_sys);
		osd_status  <= 1'b0;
		img_mounted <= 1'b0;

		// Without an image the next write must stay invisible
		start_download();
		write_word(25'd0, 16'h0000);
		finish_download(3);
		save_ram_write();
		repeat (4) @(negedge clk_sys);
		check_value("bk_ena without image", 32'd0, 32'(bk_ena));
		check_value("led without bk_ena", 32'd0, 32'(led_user));
		check_value("save sectors unchanged", sectors, wr_count);

		repeat (4) @(negedge clk_sys);
		$display("Checks complete with %0d errors", errors);
		if (errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

/* design/cart_manager_top.sv */
/*
 * Cartridge manager
 * Header parsing, save RAM dirty tracking and backup RAM sync
 */
`timescale 1ns/100ps

module cart_manager_top import cart_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	// Loader stream
	input  logic        ioctl_download,
	input  logic [7:0]  ioctl_index,
	input  logic        ioctl_wr,
	input  logic [24:0] ioctl_addr,
	input  logic [15:0] ioctl_dout,
	// Menu options
	input  rom_layout_e rom_layout,
	input  region_sel_e video_region,
	input  logic        osd_status,
	input  logic        autosave,
	input  logic        bk_load,
	input  logic        bk_save,
	// Save image
	input  logic        img_mounted,
	input  logic        img_readonly,
	input  logic [63:0] img_size,
	// Save RAM bus from the core
	input  logic        bsram_ce_n,
	input  logic        bsram_we_n,
	// SD block port
	input  logic        sd_ack,
	output logic [31:0] sd_lba,
	output logic        sd_rd,
	output logic        sd_wr,
	// Cartridge setup
	output logic        cart_download,
	output logic [7:0]  rom_type,
	output logic [23:0] rom_mask,
	output logic [23:0] ram_mask,
	output logic        pal,
	output logic        bk_ena,
	output logic        bk_busy,
	output logic        bk_loading,
	output logic        led_user
);

	logic save_req;

	cart_header_parser u_parser (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.rom_layout     (rom_layout),
		.video_region   (video_region),
		.img_mounted    (img_mounted),
		.img_readonly   (img_readonly),
		.cart_download  (cart_download),
		.rom_type       (rom_type),
		.rom_mask       (rom_mask),
		.ram_mask       (ram_mask),
		.pal            (pal),
		.bk_ena         (bk_ena)
	);

	save_dirty_tracker u_tracker (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.bsram_ce_n    (bsram_ce_n),
		.bsram_we_n    (bsram_we_n),
		.bk_ena        (bk_ena),
		.osd_status    (osd_status),
		.autosave      (autosave),
		.bk_save       (bk_save),
		.bk_busy       (bk_busy),
		.cart_download (cart_download),
		.save_req      (save_req),
		.led_user      (led_user)
	);

	backup_sync_sequencer u_sequencer (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.bk_load       (bk_load),
		.save_req      (save_req),
		.bk_ena        (bk_ena),
		.cart_download (cart_download),
		.img_size      (img_size),
		.ram_mask      (ram_mask),
		.sd_ack        (sd_ack),
		.sd_lba        (sd_lba),
		.sd_rd         (sd_rd),
		.sd_wr         (sd_wr),
		.bk_busy       (bk_busy),
		.bk_loading    (bk_loading)
	);

endmodule

/* design/backup_sync_sequencer.sv */
/*
 * Backup RAM sync sequencer
 * Moves the save RAM to or from the SD image one sector at a time
 */
`timescale 1ns/100ps
`include "cart_config.svh"

module backup_sync_sequencer import cart_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        bk_load,
	input  logic        save_req,
	input  logic        bk_ena,
	input  logic        cart_download,
	input  logic [63:0] img_size,
	input  logic [23:0] ram_mask,
	input  logic        sd_ack,
	output logic [31:0] sd_lba,
	output logic        sd_rd,
	output logic        sd_wr,
	output logic        bk_busy,
	output logic        bk_loading
);

	sync_state_e state;
	logic        load_q, load_qq;
	logic        save_q, save_qq;
	logic        dl_q, dl_qq;
	logic        ack_q;
	logic        load_start;
	logic        save_start;
	logic        ack_fall;
	logic [23:0] last_sector;

	// ============================================================
	// Start conditions
	// ============================================================

	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			load_q  <= 1'b0;
			load_qq <= 1'b0;
			save_q  <= 1'b0;
			save_qq <= 1'b0;
			dl_q    <= 1'b0;
			dl_qq   <= 1'b0;
			ack_q   <= 1'b0;
		end else begin
			load_q  <= bk_load & bk_ena;
			load_qq <= load_q;
			save_q  <= save_req & bk_ena;
			save_qq <= save_q;
			dl_q    <= cart_download;
			dl_qq   <= dl_q;
			ack_q   <= sd_ack;
		end
	end

	// End of a download pulls in an existing save file
	assign load_start = (load_q & ~load_qq) | (dl_qq & ~dl_q & (|img_size) & bk_ena);
	assign save_start = save_q & ~save_qq;
	assign ack_fall = ack_q & ~sd_ack;

	assign last_sector = ram_mask >> `CART_SECTOR_BITS;
	assign bk_busy = (state != SYNC_IDLE);

	// ============================================================
	// Sector FSM
	// ============================================================

	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			state      <= SYNC_IDLE;
			sd_lba     <= 32'd0;
			sd_rd      <= 1'b0;
			sd_wr      <= 1'b0;
			bk_loading <= 1'b0;
		end else begin
			case (state)
				SYNC_IDLE: begin
					if (load_start || save_start) begin
						state      <= SYNC_REQUEST;
						sd_lba     <= 32'd0;
						bk_loading <= load_start;
						sd_rd      <= load_start;
						sd_wr      <= ~load_start;
					end
				end
				SYNC_REQUEST: begin
					// Host has taken the sector request
					if (sd_ack) begin
						sd_rd <= 1'b0;
						sd_wr <= 1'b0;
						state <= SYNC_WAIT_END;
					end
				end
				SYNC_WAIT_END: begin
					if (ack_fall) begin
						if (sd_lba >= {8'd0, last_sector}) begin
							state      <= SYNC_IDLE;
							bk_loading <= 1'b0;
						end else begin
							state  <= SYNC_REQUEST;
							sd_lba <= sd_lba + 32'd1;
							sd_rd  <= bk_loading;
							sd_wr  <= ~bk_loading;
						end
					end
				end
				default: state <= SYNC_IDLE;
			endcase
		end
	end

endmodule

/* design/save_dirty_tracker.sv */
/*
 * Save RAM dirty tracker
 * Flags unsaved backup RAM writes, raises the save request and
 * drives the activity LED
 */
`timescale 1ns/100ps

module save_dirty_tracker import cart_pkg::*; (
	input  logic clk_sys,
	input  logic reset,
	input  logic bsram_ce_n,
	input  logic bsram_we_n,
	input  logic bk_ena,
	input  logic osd_status,
	input  logic autosave,
	input  logic bk_save,
	input  logic bk_busy,
	input  logic cart_download,
	output logic save_req,
	output logic led_user
);

	logic bsram_write;
	logic bk_pending;

	assign bsram_write = ~bsram_ce_n & ~bsram_we_n;

	// Writes made while the menu is open are not counted
	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			bk_pending <= 1'b0;
		end else if (bk_ena && !osd_status && bsram_write) begin
			bk_pending <= 1'b1;
		end else if (bk_busy) begin
			bk_pending <= 1'b0;
		end
	end

	// Autosave fires once the menu opens
	assign save_req = bk_save | (bk_pending & osd_status & autosave);

	assign led_user = cart_download | (autosave & bk_pending);

endmodule

/* design/cart_header_parser.sv */
/*
 * Cartridge header parser
 * Watches the loader stream and derives ROM type, ROM and RAM masks,
 * the video region and whether battery-backed RAM can be saved
 */
`timescale 1ns/100ps
`include "cart_config.svh"

module cart_header_parser import cart_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        ioctl_download,
	input  logic [7:0]  ioctl_index,
	input  logic        ioctl_wr,
	input  logic [24:0] ioctl_addr,
	input  logic [15:0] ioctl_dout,
	input  rom_layout_e rom_layout,
	input  region_sel_e video_region,
	input  logic        img_mounted,
	input  logic        img_readonly,
	output logic        cart_download,
	output logic [7:0]  rom_type,
	output logic [23:0] rom_mask,
	output logic [23:0] ram_mask,
	output logic        pal,
	output logic        bk_ena
);

	logic [3:0]  rom_size;
	logic [3:0]  ram_size;
	logic        rom_region;
	logic        old_download;
	logic        layout_forced;
	logic [24:0] size_addr;
	logic [24:0] ram_size_addr;

	// All-ones index is a non-cartridge target
	assign cart_download = ioctl_download & ~(&ioctl_index);

	// ============================================================
	// Forced layout header location
	// ============================================================

	always_comb begin
		layout_forced = 1'b1;
		case (rom_layout)
			LAYOUT_LOROM:   size_addr = `CART_LOROM_SIZE_ADDR + `CART_HEADER_SKIP;
			LAYOUT_HIROM:   size_addr = `CART_HIROM_SIZE_ADDR + `CART_HEADER_SKIP;
			LAYOUT_EXHIROM: size_addr = `CART_EXHIROM_SIZE_ADDR + `CART_HEADER_SKIP;
			default: begin
				layout_forced = 1'b0;
				size_addr = '0;
			end
		endcase
	end

	assign ram_size_addr = size_addr + `CART_RAM_SIZE_OFFSET;

	// ============================================================
	// Header capture
	// ============================================================

	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			rom_size   <= `CART_DEFAULT_ROM_SIZE;
			ram_size   <= 4'd0;
			rom_type   <= 8'd0;
			rom_region <= 1'b0;
		end else if (cart_download && ioctl_wr) begin
			if (ioctl_addr == 25'd0) begin
				rom_size <= `CART_DEFAULT_ROM_SIZE;
				ram_size <= 4'd0;
				// Loader puts the size nibbles in the low byte
				if (rom_layout == LAYOUT_AUTO && ioctl_dout[7:0] != 8'd0) begin
					{ram_size, rom_size} <= ioctl_dout[7:0];
				end
				case (rom_layout)
					LAYOUT_NO_HEADER: rom_type <= 8'd0;
					LAYOUT_LOROM:     rom_type <= 8'd0;
					LAYOUT_HIROM:     rom_type <= 8'd1;
					LAYOUT_EXHIROM:   rom_type <= 8'd2;
					default:          rom_type <= ioctl_dout[15:8];
				endcase
			end
			if (ioctl_addr == `CART_REGION_ADDR) begin
				rom_region <= ioctl_dout[8];
			end
			if (layout_forced && ioctl_addr == size_addr) begin
				rom_size <= ioctl_dout[11:8];
			end
			if (layout_forced && ioctl_addr == ram_size_addr) begin
				ram_size <= ioctl_dout[3:0];
			end
		end
	end

	// Masks trail the size fields by one cycle
	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			rom_mask <= 24'd0;
			ram_mask <= 24'd0;
		end else begin
			rom_mask <= (`CART_MASK_BASE << rom_size) - 24'd1;
			ram_mask <= (ram_size != 4'd0) ? (`CART_MASK_BASE << ram_size) - 24'd1 : 24'd0;
		end
	end

	assign pal = (video_region == REGION_AUTO) ? rom_region : (video_region != REGION_NTSC);

	// ============================================================
	// Save enable
	// ============================================================

	// The save image is mounted by the time the download ends
	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			old_download <= 1'b0;
			bk_ena       <= 1'b0;
		end else begin
			old_download <= cart_download;
			if (!old_download && cart_download) begin
				bk_ena <= 1'b0;
			end
			if (cart_download && img_mounted && !img_readonly) begin
				bk_ena <= |ram_mask;
			end
		end
	end

endmodule

/* design/cart_pkg.sv */
/*
 * Cartridge manager types
 * Header layout selection, video region selection and the
 * backup RAM sync FSM states
 */
package cart_pkg;

	// ============================================================
	// Menu selections
	// ============================================================

	// ROM header layout, auto takes the loader's first word
	typedef enum logic [2:0] {
		LAYOUT_AUTO      = 3'd0,
		LAYOUT_NO_HEADER = 3'd1,
		LAYOUT_LOROM     = 3'd2,
		LAYOUT_HIROM     = 3'd3,
		LAYOUT_EXHIROM   = 3'd4
	} rom_layout_e;

	// Video region, the spare code acts as PAL
	typedef enum logic [1:0] {
		REGION_AUTO     = 2'd0,
		REGION_NTSC     = 2'd1,
		REGION_PAL      = 2'd2,
		REGION_PAL_ALT  = 2'd3
	} region_sel_e;

	// ============================================================
	// Backup RAM sync FSM
	// ============================================================

	// Request holds the SD strobe, wait end waits for the ack to fall
	typedef enum logic [1:0] {
		SYNC_IDLE     = 2'd0,
		SYNC_REQUEST  = 2'd1,
		SYNC_WAIT_END = 2'd2
	} sync_state_e;

endpackage

/* include/cart_config.svh */
/*
 * Cartridge manager constants
 * Header field offsets, default sizes and the backup RAM sector width
 */
`ifndef CART_CONFIG_SVH
`define CART_CONFIG_SVH

// ============================================================
// Loader byte addresses
// ============================================================

// Copier header in front of the ROM image
`define CART_HEADER_SKIP        25'h000200

// Size field of the internal header, per layout
`define CART_LOROM_SIZE_ADDR    25'h007FD6
`define CART_HIROM_SIZE_ADDR    25'h00FFD6
`define CART_EXHIROM_SIZE_ADDR  25'h40FFD6

// RAM size field follows the ROM size field
`define CART_RAM_SIZE_OFFSET    25'h000002

// Byte 1 bit 0 of this word carries the ROM region
`define CART_REGION_ADDR        25'h000002

// ============================================================
// Sizes
// ============================================================

`define CART_DEFAULT_ROM_SIZE   4'hC
`define CART_MASK_BASE          24'd1024
`define CART_SECTOR_BITS        9

`endif
